// ==== ex_defs.svh ====
/*
  execute stage sizing macros
  EX_XLEN is fixed at 64 by the Alpha encodings in the integer path
  EX_TAG_W must cover every tag that can be in flight at once
  EX_MULT_STAGES must be 2 or more
*/
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

//////////////////////////////
// datapath
//////////////////////////////

// machine word
`define EX_XLEN 64

// destination tag carried to the bus
`define EX_TAG_W 6

//////////////////////////////
// multiplier
//////////////////////////////

// pipe depth, one multiplier slice per stage
`define EX_MULT_STAGES 4

`endif

// ==== ex_pkg.sv ====
/*
  shared types of the execute stage
  inst_word_u assumes the Alpha 32-bit layout, opcode in bits 31:26
  the memory displacement is taken from the low 16 bits of either view
*/
`include "ex_defs.svh"

package ex_pkg;

  //////////////////////////////
  // control encodings
  //////////////////////////////

  // ALU function select
  typedef enum logic [3:0] {
    ALU_ADDQ   = 4'h0,
    ALU_SUBQ   = 4'h1,
    ALU_AND    = 4'h2,
    ALU_BIC    = 4'h3,
    ALU_BIS    = 4'h4,
    ALU_ORNOT  = 4'h5,
    ALU_XOR    = 4'h6,
    ALU_EQV    = 4'h7,
    ALU_SRL    = 4'h8,
    ALU_SLL    = 4'h9,
    ALU_SRA    = 4'ha,
    ALU_CMPULT = 4'hb,
    ALU_CMPEQ  = 4'hc,
    ALU_CMPULE = 4'hd,
    ALU_CMPLT  = 4'he,
    ALU_CMPLE  = 4'hf
  } alu_func_e;

  // operand A source
  typedef enum logic [1:0] {
    ALU_OPA_IS_REGA     = 2'h0,
    ALU_OPA_IS_MEM_DISP = 2'h1,
    ALU_OPA_IS_NPC      = 2'h2,
    ALU_OPA_IS_NOT3     = 2'h3
  } opa_sel_e;

  // operand B source, code 3 unused
  typedef enum logic [1:0] {
    ALU_OPB_IS_REGB    = 2'h0,
    ALU_OPB_IS_ALU_IMM = 2'h1,
    ALU_OPB_IS_BR_DISP = 2'h2
  } opb_sel_e;

  //////////////////////////////
  // instruction word
  //////////////////////////////

  // operate format, literal in 20:13
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [7:0]  alu_imm;
    logic [12:0] func;
  } op_fmt_t;

  // branch format
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  ra;
    logic [20:0] disp;
  } br_fmt_t;

  typedef union packed {
    op_fmt_t op;
    br_fmt_t br;
  } inst_word_u;

  // what goes out on the bus
  typedef struct packed {
    logic [`EX_TAG_W-1:0] tag;
    logic [`EX_XLEN-1:0]  value;
    logic                 take_branch;
  } ex_result_t;

endpackage

// ==== ex_result_if.sv ====
/*
  valid/ready result channel between a functional unit and the arbiter
  transfer on a rising edge with valid and ready both high
  producer holds data and valid steady while ready is low
*/
`timescale 1ns/1ps

interface ex_result_if import ex_pkg::*; ();

  // handshake
  logic       valid;
  logic       ready;

  // tag, value and take_branch
  ex_result_t data;

  // functional unit side
  modport producer (
    output valid,
    output data,
    input  ready
  );

  // arbiter side
  modport consumer (
    input  valid,
    input  data,
    output ready
  );

endinterface

// ==== ex_int_unit.sv ====
/*
  integer path: operand muxes, ALU, branch condition
  one-entry output register, so one op per cycle at full rate
  int_ready is low only while the register is full and not draining
  take_branch only, no redirect of fetch
*/
`include "ex_defs.svh"
`timescale 1ns/1ps

module ex_int_unit import ex_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 int_valid,
  output logic                 int_ready,
  input  logic [`EX_TAG_W-1:0] int_tag,
  input  inst_word_u           int_inst,
  input  logic [`EX_XLEN-1:0]  int_npc,
  input  logic [`EX_XLEN-1:0]  int_rega,
  input  logic [`EX_XLEN-1:0]  int_regb,
  input  opa_sel_e             int_opa_sel,
  input  opb_sel_e             int_opb_sel,
  input  alu_func_e            int_func,
  input  logic                 int_cond_br,
  input  logic                 int_uncond_br,
  ex_result_if.producer        res
);

  localparam int SHW = $clog2(`EX_XLEN);

  logic [`EX_XLEN-1:0] mem_disp;
  logic [`EX_XLEN-1:0] br_disp;
  logic [`EX_XLEN-1:0] alu_imm;
  logic [`EX_XLEN-1:0] opa;
  logic [`EX_XLEN-1:0] opb;
  logic [`EX_XLEN-1:0] alu_out;
  logic [2:0]          cc;
  logic                cond;
  logic                take_branch;
  logic                out_valid;
  ex_result_t          out_data;

  //////////////////////////////
  // immediates
  //////////////////////////////

  // memory disp, sign extend 16
  assign mem_disp = {{(`EX_XLEN-16){int_inst.br.disp[15]}}, int_inst.br.disp[15:0]};
  // branch disp, sign extend 21, word aligned
  assign br_disp  = {{(`EX_XLEN-23){int_inst.br.disp[20]}}, int_inst.br.disp, 2'b00};
  // literal is unsigned
  assign alu_imm  = {{(`EX_XLEN-8){1'b0}}, int_inst.op.alu_imm};

  // operand A
  always_comb begin
    case (int_opa_sel)
      ALU_OPA_IS_REGA:     opa = int_rega;
      ALU_OPA_IS_MEM_DISP: opa = mem_disp;
      ALU_OPA_IS_NPC:      opa = int_npc;
      default:             opa = ~`EX_XLEN'(3);
    endcase
  end

  // operand B, unused code gives zero
  always_comb begin
    case (int_opb_sel)
      ALU_OPB_IS_REGB:    opb = int_regb;
      ALU_OPB_IS_ALU_IMM: opb = alu_imm;
      ALU_OPB_IS_BR_DISP: opb = br_disp;
      default:            opb = '0;
    endcase
  end

  //////////////////////////////
  // ALU
  //////////////////////////////

  always_comb begin
    alu_out = '0;
    case (int_func)
      ALU_ADDQ:   alu_out = opa + opb;
      ALU_SUBQ:   alu_out = opa - opb;
      ALU_AND:    alu_out = opa & opb;
      ALU_BIC:    alu_out = opa & ~opb;
      ALU_BIS:    alu_out = opa | opb;
      ALU_ORNOT:  alu_out = opa | ~opb;
      ALU_XOR:    alu_out = opa ^ opb;
      ALU_EQV:    alu_out = ~(opa ^ opb);
      // shift count is low bits of B only
      ALU_SRL:    alu_out = opa >> opb[SHW-1:0];
      ALU_SLL:    alu_out = opa << opb[SHW-1:0];
      ALU_SRA:    alu_out = $signed(opa) >>> opb[SHW-1:0];
      // compares return 0 or 1
      ALU_CMPULT: alu_out = `EX_XLEN'(opa < opb);
      ALU_CMPEQ:  alu_out = `EX_XLEN'(opa == opb);
      ALU_CMPULE: alu_out = `EX_XLEN'(opa <= opb);
      ALU_CMPLT:  alu_out = `EX_XLEN'($signed(opa) < $signed(opb));
      ALU_CMPLE:  alu_out = `EX_XLEN'($signed(opa) <= $signed(opb));
      default:    alu_out = '0;
    endcase
  end

  //////////////////////////////
  // branch condition
  //////////////////////////////

  // condition code sits in opcode bits 28:26
  assign cc = int_inst.op.opcode[2:0];

  // always tested on rega, cc[2] inverts
  always_comb begin
    case (cc[1:0])
      2'b00:   cond = ~int_rega[0];
      2'b01:   cond = (int_rega == '0);
      2'b10:   cond = int_rega[`EX_XLEN-1];
      default: cond = int_rega[`EX_XLEN-1] | (int_rega == '0);
    endcase
  end

  assign take_branch = int_uncond_br | (int_cond_br & (cond ^ cc[2]));

  //////////////////////////////
  // output register
  //////////////////////////////

  // accept while empty or draining this cycle
  assign int_ready = ~out_valid | res.ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (int_valid && int_ready) begin
      out_valid <= 1'b1;
    end else if (res.ready) begin
      out_valid <= 1'b0;
    end
  end

  // payload only moves on accept
  always_ff @(posedge clock) begin
    if (int_valid && int_ready) begin
      out_data.tag         <= int_tag;
      out_data.value       <= alu_out;
      out_data.take_branch <= take_branch;
    end
  end

  assign res.valid = out_valid;
  assign res.data  = out_data;

endmodule

// ==== ex_mult_pipe.sv ====
/*
  pipelined multiplier, EX_MULT_STAGES deep, low 64 bits of product only
  operands are unsigned with one slice of the multiplier summed per stage
  a full last stage that cannot drain freezes the whole pipe
  up to EX_MULT_STAGES products in flight
*/
`include "ex_defs.svh"
`timescale 1ns/1ps

module ex_mult_pipe import ex_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 mul_valid,
  output logic                 mul_ready,
  input  logic [`EX_TAG_W-1:0] mul_tag,
  input  logic [`EX_XLEN-1:0]  mul_opa,
  input  logic [`EX_XLEN-1:0]  mul_opb,
  ex_result_if.producer        res
);

  localparam int STAGES = `EX_MULT_STAGES;
  // multiplier bits handled per stage
  localparam int CHUNK = (`EX_XLEN + STAGES - 1) / STAGES;

  logic [STAGES-1:0]    st_valid;
  logic [`EX_TAG_W-1:0] st_tag    [STAGES];
  logic [`EX_XLEN-1:0]  st_prod   [STAGES];
  // shifted operands feed the next stage only, none kept after the last
  logic [`EX_XLEN-1:0]  st_mcand  [STAGES-1];
  logic [`EX_XLEN-1:0]  st_mplier [STAGES-1];
  logic                 advance;

  // acc plus mcand times low slice of mplier
  function automatic logic [`EX_XLEN-1:0] mac_chunk(
    input logic [`EX_XLEN-1:0] acc,
    input logic [`EX_XLEN-1:0] mcand,
    input logic [`EX_XLEN-1:0] mplier
  );
    logic [`EX_XLEN-1:0] digit;
    digit = {{(`EX_XLEN-CHUNK){1'b0}}, mplier[CHUNK-1:0]};
    return acc + mcand * digit;
  endfunction

  // global stall
  assign advance   = ~st_valid[STAGES-1] | res.ready;
  assign mul_ready = advance;

  always_ff @(posedge clock) begin
    if (reset) begin
      st_valid <= '0;
    end else if (advance) begin
      st_valid <= {st_valid[STAGES-2:0], mul_valid};
    end
  end

  //////////////////////////////
  // partial products
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (advance) begin
      // first slice at entry
      st_tag[0]    <= mul_tag;
      st_prod[0]   <= mac_chunk('0, mul_opa, mul_opb);
      st_mcand[0]  <= mul_opa << CHUNK;
      st_mplier[0] <= mul_opb >> CHUNK;
      for (int k = 1; k < STAGES; k++) begin
        st_tag[k]  <= st_tag[k-1];
        st_prod[k] <= mac_chunk(st_prod[k-1], st_mcand[k-1], st_mplier[k-1]);
      end
      for (int k = 1; k < STAGES - 1; k++) begin
        st_mcand[k]  <= st_mcand[k-1] << CHUNK;
        st_mplier[k] <= st_mplier[k-1] >> CHUNK;
      end
    end
  end

  // last stage drives the channel
  assign res.valid            = st_valid[STAGES-1];
  assign res.data.tag         = st_tag[STAGES-1];
  assign res.data.value       = st_prod[STAGES-1];
  assign res.data.take_branch = 1'b0;

endmodule

// ==== ex_complete_arb.sv ====
/*
  merges the integer and multiply results onto one bus port
  purely combinational select, alternating priority under contention
  grant memory moves only on a bus transfer
*/
`include "ex_defs.svh"
`timescale 1ns/1ps

module ex_complete_arb import ex_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  ex_result_if.consumer        int_res,
  ex_result_if.consumer        mul_res,
  output logic                 cdb_valid,
  output logic [`EX_TAG_W-1:0] cdb_tag,
  output logic [`EX_XLEN-1:0]  cdb_value,
  output logic                 cdb_take_branch,
  input  logic                 cdb_ready
);

  logic       last_mul;
  logic       grant_int;
  logic       grant_mul;
  ex_result_t win;

  //////////////////////////////
  // grant
  //////////////////////////////

  // when both request the side that lost last time goes
  assign grant_int = int_res.valid & (~mul_res.valid | last_mul);
  assign grant_mul = mul_res.valid & (~int_res.valid | ~last_mul);

  // remember the winner of each transfer
  always_ff @(posedge clock) begin
    if (reset) begin
      last_mul <= 1'b0;
    end else if (cdb_valid && cdb_ready) begin
      last_mul <= grant_mul;
    end
  end

  //////////////////////////////
  // bus port
  //////////////////////////////

  assign win = grant_mul ? mul_res.data : int_res.data;

  assign cdb_valid       = int_res.valid | mul_res.valid;
  assign cdb_tag         = win.tag;
  assign cdb_value       = win.value;
  assign cdb_take_branch = win.take_branch;

  // only the granted side sees ready
  assign int_res.ready = grant_int & cdb_ready;
  assign mul_res.ready = grant_mul & cdb_ready;

endmodule

// ==== ex_stage.sv ====
/*
  execute stage top: integer path, multiply path and bus arbiter
  each issue port is valid/ready, cdb_ready low stalls both paths
  results leave in no fixed order, match them by tag
*/
`include "ex_defs.svh"
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  // integer issue
  input  logic                 int_valid,
  output logic                 int_ready,
  input  logic [`EX_TAG_W-1:0] int_tag,
  input  inst_word_u           int_inst,
  input  logic [`EX_XLEN-1:0]  int_npc,
  input  logic [`EX_XLEN-1:0]  int_rega,
  input  logic [`EX_XLEN-1:0]  int_regb,
  input  opa_sel_e             int_opa_sel,
  input  opb_sel_e             int_opb_sel,
  input  alu_func_e            int_func,
  input  logic                 int_cond_br,
  input  logic                 int_uncond_br,
  // multiply issue
  input  logic                 mul_valid,
  output logic                 mul_ready,
  input  logic [`EX_TAG_W-1:0] mul_tag,
  input  logic [`EX_XLEN-1:0]  mul_opa,
  input  logic [`EX_XLEN-1:0]  mul_opb,
  // common data bus
  output logic                 cdb_valid,
  input  logic                 cdb_ready,
  output logic [`EX_TAG_W-1:0] cdb_tag,
  output logic [`EX_XLEN-1:0]  cdb_value,
  output logic                 cdb_take_branch
);

  ex_result_if int_res ();
  ex_result_if mul_res ();

  ex_int_unit u_int (
    .clock, .reset,
    .int_valid, .int_ready, .int_tag, .int_inst, .int_npc,
    .int_rega, .int_regb, .int_opa_sel, .int_opb_sel, .int_func,
    .int_cond_br, .int_uncond_br,
    .res (int_res.producer)
  );

  ex_mult_pipe u_mult (
    .clock, .reset,
    .mul_valid, .mul_ready, .mul_tag, .mul_opa, .mul_opb,
    .res (mul_res.producer)
  );

  ex_complete_arb u_arb (
    .clock, .reset,
    .int_res (int_res.consumer),
    .mul_res (mul_res.consumer),
    .cdb_valid, .cdb_tag, .cdb_value, .cdb_take_branch, .cdb_ready
  );

endmodule

// ==== ex_stage_assert.sv ====
/*
  protocol checks bound into ex_stage
  sees the top-level ports and the two internal result channels
  fail_count counts failed checks for the testbench to watch
*/
`include "ex_defs.svh"
`timescale 1ns/1ps

module ex_stage_assert import ex_pkg::*; (
  input logic                 clock,
  input logic                 reset,
  input logic                 int_ready,
  input logic                 mul_ready,
  input logic                 cdb_valid,
  input logic                 cdb_ready,
  input logic [`EX_TAG_W-1:0] cdb_tag,
  input logic [`EX_XLEN-1:0]  cdb_value,
  input logic                 cdb_take_branch,
  input logic                 int_res_valid,
  input logic                 int_res_ready,
  input ex_result_t           int_res_data,
  input logic                 mul_res_valid,
  input logic                 mul_res_ready,
  input ex_result_t           mul_res_data
);

  int unsigned fail_count = 0;

  //////////////////////////////
  // reset
  //////////////////////////////

  // both issue ports open right after reset
  ready_after_reset: assert property (@(posedge clock) $fell(reset) |-> int_ready && mul_ready)
    else begin
      $error("issue ready low right after reset");
      fail_count++;
    end

  no_x_valid: assert property (@(posedge clock) !reset |-> !$isunknown(cdb_valid))
    else begin
      $error("cdb_valid unknown");
      fail_count++;
    end

  //////////////////////////////
  // stalls
  //////////////////////////////

  // bus request stays up and payload is fixed while the requesters stay the same
  bus_hold: assert property (@(posedge clock) disable iff (reset)
    (cdb_valid && !cdb_ready) |=> cdb_valid &&
    (!$stable({int_res_valid, mul_res_valid}) || $stable({cdb_tag, cdb_value, cdb_take_branch})))
    else begin
      $error("bus payload moved under a stall");
      fail_count++;
    end

  // each producer holds its result until it leaves
  int_hold: assert property (@(posedge clock) disable iff (reset)
    (int_res_valid && !int_res_ready) |=> int_res_valid && $stable(int_res_data))
    else begin
      $error("integer result dropped or changed while waiting");
      fail_count++;
    end

  mul_hold: assert property (@(posedge clock) disable iff (reset)
    (mul_res_valid && !mul_res_ready) |=> mul_res_valid && $stable(mul_res_data))
    else begin
      $error("multiply result dropped or changed while waiting");
      fail_count++;
    end

  //////////////////////////////
  // arbitration
  //////////////////////////////

  // every bus transfer drains exactly one producer
  one_drain: assert property (@(posedge clock) disable iff (reset)
    (cdb_valid && cdb_ready) |-> (int_res_ready != mul_res_ready))
    else begin
      $error("bus transfer did not drain exactly one result");
      fail_count++;
    end

  // back to back contended transfers switch sides
  alternate: assert property (@(posedge clock) disable iff (reset)
    (int_res_valid && mul_res_valid && cdb_ready) ##1
    (int_res_valid && mul_res_valid && cdb_ready) |-> mul_res_ready != $past(mul_res_ready))
    else begin
      $error("grant did not alternate under contention");
      fail_count++;
    end

endmodule

bind ex_stage ex_stage_assert u_assert (
  .clock, .reset, .int_ready, .mul_ready,
  .cdb_valid, .cdb_ready, .cdb_tag, .cdb_value, .cdb_take_branch,
  .int_res_valid (int_res.valid),
  .int_res_ready (int_res.ready),
  .int_res_data  (int_res.data),
  .mul_res_valid (mul_res.valid),
  .mul_res_ready (mul_res.ready),
  .mul_res_data  (mul_res.data)
);

// ==== tb_ex_stage.sv ====
/*
  testbench for the execute stage, fixed seed random stimulus
  integer ops take tags 0..31 and multiply ops 32..63, cycled
  expected results come from a model of the ISA rules, kept per tag
  protocol checks live in the bound ex_stage_assert
*/
`include "ex_defs.svh"
`timescale 1ns/1ps

module tb_ex_stage import ex_pkg::*; ();

  localparam int N_INT      = 300;
  localparam int N_MUL      = 300;
  // about 6 cycles per op with stalls, plus reset
  localparam int MAX_CYCLES = (N_INT + N_MUL) * 6 + 400;

  logic                 clock;
  logic                 reset;
  logic                 int_valid;
  logic                 int_ready;
  logic [`EX_TAG_W-1:0] int_tag;
  inst_word_u           int_inst;
  logic [`EX_XLEN-1:0]  int_npc;
  logic [`EX_XLEN-1:0]  int_rega;
  logic [`EX_XLEN-1:0]  int_regb;
  opa_sel_e             int_opa_sel;
  opb_sel_e             int_opb_sel;
  alu_func_e            int_func;
  logic                 int_cond_br;
  logic                 int_uncond_br;
  logic                 mul_valid;
  logic                 mul_ready;
  logic [`EX_TAG_W-1:0] mul_tag;
  logic [`EX_XLEN-1:0]  mul_opa;
  logic [`EX_XLEN-1:0]  mul_opb;
  logic                 cdb_valid;
  logic                 cdb_ready;
  logic [`EX_TAG_W-1:0] cdb_tag;
  logic [`EX_XLEN-1:0]  cdb_value;
  logic                 cdb_take_branch;

  integer seed = 32'h24c6;
  int     cycle_count = 0;
  int     int_issued = 0;
  int     mul_issued = 0;
  int     int_accepted = 0;
  int     mul_accepted = 0;
  int     outstanding = 0;

  // scoreboard, one slot per tag
  logic                pending   [64];
  logic [`EX_XLEN-1:0] exp_value [64];
  logic                exp_take  [64];

  ex_stage u_dut (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // operand A and B from the select codes, then the ALU function
  function automatic logic [63:0] alu_model(input logic [31:0] w, input logic [63:0] npc,
      input logic [63:0] rega, input logic [63:0] regb, input opa_sel_e asel,
      input opb_sel_e bsel, input alu_func_e f);
    logic [63:0] a;
    logic [63:0] b;
    case (asel)
      ALU_OPA_IS_REGA:     a = rega;
      ALU_OPA_IS_MEM_DISP: a = 64'($signed(w[15:0]));
      ALU_OPA_IS_NPC:      a = npc;
      default:             a = 64'hffff_ffff_ffff_fffc;
    endcase
    case (bsel)
      ALU_OPB_IS_REGB:    b = regb;
      ALU_OPB_IS_ALU_IMM: b = {56'd0, w[20:13]};
      default:            b = 64'($signed({w[20:0], 2'b00}));
    endcase
    case (f)
      ALU_ADDQ:   return a + b;
      ALU_SUBQ:   return a - b;
      ALU_AND:    return a & b;
      ALU_BIC:    return a & ~b;
      ALU_BIS:    return a | b;
      ALU_ORNOT:  return a | ~b;
      ALU_XOR:    return a ^ b;
      ALU_EQV:    return a ^ ~b;
      ALU_SRL:    return a >> b[5:0];
      ALU_SLL:    return a << b[5:0];
      ALU_SRA:    return 64'($signed(a) >>> b[5:0]);
      ALU_CMPULT: return {63'd0, a < b};
      ALU_CMPEQ:  return {63'd0, a == b};
      ALU_CMPULE: return {63'd0, a <= b};
      ALU_CMPLT:  return {63'd0, $signed(a) < $signed(b)};
      default:    return {63'd0, $signed(a) <= $signed(b)};
    endcase
  endfunction

  // condition code in bits 28:26, top bit inverts
  function automatic logic branch_model(input logic [31:0] w, input logic [63:0] rega,
      input logic cond_br, input logic uncond_br);
    logic hit;
    case (w[27:26])
      2'd0:    hit = (rega[0] == 1'b0);
      2'd1:    hit = (rega == 64'd0);
      2'd2:    hit = rega[63];
      default: hit = rega[63] || (rega == 64'd0);
    endcase
    return uncond_br || (cond_br && (hit != w[28]));
  endfunction

  // corners for compares, shifts and branch tests
  function automatic logic [63:0] pick_operand();
    logic [31:0] r;
    r = $random(seed);
    case (r[3:0])
      4'd0:    return 64'd0;
      4'd1:    return 64'd1;
      4'd2:    return 64'd63;
      4'd3:    return 64'h8000_0000_0000_0000;
      4'd4:    return 64'h7fff_ffff_ffff_ffff;
      4'd5:    return 64'hffff_ffff_ffff_ffff;
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  //////////////////////////////
  // stimulus and scoreboard
  //////////////////////////////

  task automatic new_int_op(input int n);
    logic [31:0] r;
    logic [31:0] w;
    r = $random(seed);
    w = $random(seed);
    int_tag       <= {1'b0, 5'(n)};
    int_inst      <= w;
    int_npc       <= {$random(seed), $random(seed)};
    int_rega      <= pick_operand();
    int_regb      <= pick_operand();
    int_opa_sel   <= opa_sel_e'(r[1:0]);
    // code 3 of the B select is unused
    int_opb_sel   <= (r[3:2] == 2'b11) ? ALU_OPB_IS_REGB : opb_sel_e'(r[3:2]);
    int_func      <= alu_func_e'(r[7:4]);
    int_cond_br   <= (r[9:8] == 2'b00);
    int_uncond_br <= (r[12:10] == 3'b000);
  endtask

  task automatic new_mul_op(input int n);
    mul_tag <= {1'b1, 5'(n)};
    mul_opa <= pick_operand();
    mul_opb <= pick_operand();
  endtask

  task automatic record_issue(input logic [`EX_TAG_W-1:0] tag, input logic [63:0] value,
      input logic take);
    assert (!pending[tag]) else begin
      $display("tag %0h issued again while its result is still outstanding", tag);
      $display("Some tests failed");
      $fatal(1, "tag reuse");
    end
    pending[tag]   = 1'b1;
    exp_value[tag] = value;
    exp_take[tag]  = take;
    outstanding++;
  endtask

  task automatic check_result();
    assert (pending[cdb_tag]) else begin
      $display("bus result for tag %0h that is not outstanding", cdb_tag);
      $display("Some tests failed");
      $fatal(1, "unexpected or duplicate tag");
    end
    assert (cdb_value == exp_value[cdb_tag]) else begin
      $display("[ERROR] cdb_value tag %0h got %h expected %h", cdb_tag, cdb_value,
               exp_value[cdb_tag]);
      $display("Some tests failed");
      $fatal(1, "value mismatch");
    end
    assert (cdb_take_branch == exp_take[cdb_tag]) else begin
      $display("[ERROR] cdb_take_branch tag %0h got %h expected %h", cdb_tag,
               cdb_take_branch, exp_take[cdb_tag]);
      $display("Some tests failed");
      $fatal(1, "take_branch mismatch");
    end
    pending[cdb_tag] = 1'b0;
    outstanding--;
  endtask

  // retire, record accepts, then drive the next inputs
  always @(posedge clock) begin : drive_and_score
    logic [31:0] r;
    if (!reset) begin
      if (cdb_valid && cdb_ready) begin
        check_result();
      end
      if (int_valid && int_ready) begin
        record_issue(int_tag, alu_model(int_inst, int_npc, int_rega, int_regb, int_opa_sel,
                     int_opb_sel, int_func),
                     branch_model(int_inst, int_rega, int_cond_br, int_uncond_br));
        int_accepted++;
      end
      if (mul_valid && mul_ready) begin
        record_issue(mul_tag, mul_opa * mul_opb, 1'b0);
        mul_accepted++;
      end
      r = $random(seed);
      if (!int_valid || int_ready) begin
        if (int_issued < N_INT && r[1:0] != 2'b00) begin
          new_int_op(int_issued);
          int_issued++;
          int_valid <= 1'b1;
        end else begin
          int_valid <= 1'b0;
        end
      end
      if (!mul_valid || mul_ready) begin
        if (mul_issued < N_MUL && r[3:2] != 2'b00) begin
          new_mul_op(mul_issued);
          mul_issued++;
          mul_valid <= 1'b1;
        end else begin
          mul_valid <= 1'b0;
        end
      end
      // random bus stalls
      cdb_ready <= (r[5:4] != 2'b00);
    end
  end

  // timeout and bound check watch
  always @(negedge clock) begin
    cycle_count <= cycle_count + 1;
    if (u_dut.u_assert.fail_count != 0) begin
      $display("Some tests failed");
      $fatal(1, "protocol assertion failed inside ex_stage");
    end else if (cycle_count >= MAX_CYCLES) begin
      $display("Some tests failed");
      $fatal(1, "timeout with %0d results outstanding", outstanding);
    end
  end

  initial begin
    for (int i = 0; i < 64; i++) begin
      pending[i] = 1'b0;
    end
    reset         = 1'b1;
    int_valid     = 1'b0;
    int_tag       = '0;
    int_inst      = '0;
    int_npc       = '0;
    int_rega      = '0;
    int_regb      = '0;
    int_opa_sel   = ALU_OPA_IS_REGA;
    int_opb_sel   = ALU_OPB_IS_REGB;
    int_func      = ALU_ADDQ;
    int_cond_br   = 1'b0;
    int_uncond_br = 1'b0;
    mul_valid     = 1'b0;
    mul_tag       = '0;
    mul_opa       = '0;
    mul_opb       = '0;
    cdb_ready     = 1'b0;
    repeat (10) @(posedge clock);
    reset <= 1'b0;
    while (int_accepted < N_INT || mul_accepted < N_MUL || outstanding != 0) begin
      @(posedge clock);
    end
    // one more edge for the bound checks
    @(posedge clock);
    if (outstanding == 0 && u_dut.u_assert.fail_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("Some tests failed");
      $fatal(1, "run ended with failed checks");
    end
  end

endmodule

// ==== ex_stage.f ====
+incdir+.
ex_pkg.sv
ex_result_if.sv
ex_int_unit.sv
ex_mult_pipe.sv
ex_complete_arb.sv
ex_stage.sv
ex_stage_assert.sv
tb_ex_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ex_stage -f ex_stage.f \
  -o sim_ex_stage > build.log 2>&1 || { cat build.log; exit 1; }
# keep running past a failed assertion so the testbench reports it
./obj_dir/sim_ex_stage +verilator+error+limit+100 > sim.log 2>&1 || echo "simulator exit nonzero"
cat sim.log
grep -q "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
